/* source/controller.sv */
`default_nettype none

module controller
	import cpu_pkg::*;
(
	input  logic            clock,
	input  logic            reset,
	output logic            imem_req,
	output logic [xlen-1:0] imem_addr,
	input  logic            imem_ack,
	input  logic [xlen-1:0] imem_rdata,
	output logic            dmem_req,
	output mem_req_t        dmem_out,
	input  logic            dmem_ack,
	input  logic [xlen-1:0] dmem_rdata,
	input  logic            branch_taken,
	input  logic [xlen-1:0] branch_target,
	input  logic [xlen-1:0] mem_addr,
	input  logic [xlen-1:0] rt_data,
	output ctrl_t           ctrl,
	output logic            reg_wr_en,
	output logic [xlen-1:0] load_data
);

	phase_t phase;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] ir;
	logic imem_done;
	logic mem_op;
	ctrl_t decoded;
	opcode_t opcode;
	base_subop_t base_subop;
	ls_subop_t ls_subop;

	assign opcode = opcode_t'(ir[30:25]);
	assign base_subop = base_subop_t'(ir[4:0]);
	assign ls_subop = ls_subop_t'(ir[7:0]);

	// pc is held stable for the whole instruction
	assign imem_addr = pc;
	assign mem_op = ctrl.dm_read || ctrl.dm_write;
	assign reg_wr_en = (phase == writeback) && ctrl.reg_write;

	// unknown encodings fall through as no-ops
	always_comb begin
		decoded = '0;
		decoded.alu_op = alu_pass;
		decoded.alu_src2 = src2_none;
		decoded.imm_ext = ext_none;
		decoded.wb_src = wb_none;
		decoded.sv = ir[9:8];
		decoded.ra = ir[19:15];
		decoded.rb = ir[14:10];
		decoded.rt = ir[24:20];
		decoded.imm = ir[23:0];
		case (opcode)
			ty_base: begin
				decoded.alu_src2 = src2_rb_data;
				decoded.wb_src = wb_alu_result;
				decoded.reg_write = 1'b1;
				case (base_subop)
					add:    decoded.alu_op = alu_add;
					sub:    decoded.alu_op = alu_sub;
					and_op: decoded.alu_op = alu_and;
					or_op:  decoded.alu_op = alu_or;
					xor_op: decoded.alu_op = alu_xor;
					srli, slli, rotri: begin
						decoded.alu_src2 = src2_imm;
						decoded.imm_ext = ext_imm5_ze;
						decoded.alu_op = (base_subop == srli) ? alu_srl :
							(base_subop == slli) ? alu_sll : alu_rotr;
					end
					default: begin
						decoded.reg_write = 1'b0;
						decoded.wb_src = wb_none;
					end
				endcase
			end
			addi, ori, xori: begin
				decoded.alu_src2 = src2_imm;
				decoded.wb_src = wb_alu_result;
				decoded.reg_write = 1'b1;
				decoded.imm_ext = (opcode == addi) ? ext_imm15_se : ext_imm15_ze;
				decoded.alu_op = (opcode == addi) ? alu_add :
					(opcode == ori) ? alu_or : alu_xor;
			end
			movi: begin
				decoded.alu_src2 = src2_imm;
				decoded.imm_ext = ext_imm20_se;
				decoded.wb_src = wb_imm_data;
				decoded.reg_write = 1'b1;
			end
			lwi, swi: begin
				decoded.alu_op = alu_add;
				decoded.alu_src2 = src2_lswi_offset;
				decoded.dm_read = (opcode == lwi);
				decoded.dm_write = (opcode == swi);
				decoded.reg_write = (opcode == lwi);
				decoded.wb_src = (opcode == lwi) ? wb_load_data : wb_none;
			end
			ty_ls: begin
				decoded.alu_op = alu_add;
				decoded.alu_src2 = src2_lsw_index;
				decoded.dm_read = (ls_subop == lw);
				decoded.dm_write = (ls_subop == sw);
				decoded.reg_write = (ls_subop == lw);
				decoded.wb_src = (ls_subop == lw) ? wb_load_data : wb_none;
			end
			ty_b: begin
				decoded.alu_op = alu_sub;
				decoded.alu_src2 = src2_branch;
				decoded.is_branch = 1'b1;
				decoded.branch_ne = ir[14];
			end
			jj:      decoded.is_jump = 1'b1;
			default: decoded.alu_op = alu_pass;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			phase <= fetch;
			pc <= '0;
			imem_req <= 1'b0;
			dmem_req <= 1'b0;
			imem_done <= 1'b0;
			ctrl <= '0;
		end else begin
			case (phase)
				fetch: begin
					if (imem_req) begin
						if (imem_ack) begin
							imem_req <= 1'b0;
							imem_done <= 1'b1;
						end
					end else if (!imem_ack) begin
						// ack low again means start or finish
						if (imem_done) begin
							imem_done <= 1'b0;
							phase <= decode;
						end else begin
							imem_req <= 1'b1;
						end
					end
				end
				decode: begin
					ctrl <= decoded;
					phase <= execute;
				end
				execute: begin
					dmem_req <= mem_op;
					phase <= memaccess;
				end
				memaccess: begin
					if (!mem_op) begin
						phase <= writeback;
					end else if (dmem_req) begin
						if (dmem_ack) begin
							dmem_req <= 1'b0;
						end
					end else if (!dmem_ack) begin
						phase <= writeback;
					end
				end
				writeback: begin
					pc <= branch_taken ? branch_target : pc + pc_step;
					imem_req <= 1'b1;
					phase <= fetch;
				end
				default: phase <= fetch;
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clock) begin
		if (phase == fetch && imem_req && imem_ack) begin
			ir <= imem_rdata;
		end
		if (phase == execute) begin
			dmem_out.addr <= mem_addr;
			dmem_out.wdata <= rt_data;
			dmem_out.write <= ctrl.dm_write;
		end
		if (phase == memaccess && dmem_req && dmem_ack) begin
			load_data <= dmem_rdata;
		end
	end

	// only one bus active at a time
	assert property (@(posedge clock) disable iff (reset) !(imem_req && dmem_req));

	// req holds until ack is seen
	assert property (@(posedge clock) disable iff (reset)
		imem_req && !imem_ack |=> imem_req);
	assert property (@(posedge clock) disable iff (reset)
		dmem_req && !dmem_ack |=> dmem_req);

endmodule

`default_nettype wire

/* source/cpu_core.sv */
`default_nettype none

module cpu_core
	import cpu_pkg::*;
(
	input  logic            clock,
	input  logic            reset,
	output logic            imem_req,
	output logic [xlen-1:0] imem_addr,
	input  logic            imem_ack,
	input  logic [xlen-1:0] imem_rdata,
	output logic            dmem_req,
	output mem_req_t        dmem_out,
	input  logic            dmem_ack,
	input  logic [xlen-1:0] dmem_rdata
);

	ctrl_t ctrl;
	logic reg_wr_en;
	logic [xlen-1:0] ra_data;
	logic [xlen-1:0] rb_data;
	logic [xlen-1:0] rt_data;
	logic [xlen-1:0] load_data;
	logic [xlen-1:0] mem_addr;
	logic branch_taken;
	logic [xlen-1:0] branch_target;
	logic [xlen-1:0] wb_value;

	controller controller_inst (
		.clock         (clock),
		.reset         (reset),
		.imem_req      (imem_req),
		.imem_addr     (imem_addr),
		.imem_ack      (imem_ack),
		.imem_rdata    (imem_rdata),
		.dmem_req      (dmem_req),
		.dmem_out      (dmem_out),
		.dmem_ack      (dmem_ack),
		.dmem_rdata    (dmem_rdata),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.mem_addr      (mem_addr),
		.rt_data       (rt_data),
		.ctrl          (ctrl),
		.reg_wr_en     (reg_wr_en),
		.load_data     (load_data)
	);

	register_file register_file_inst (
		.clock   (clock),
		.reset   (reset),
		.ra      (ctrl.ra),
		.rb      (ctrl.rb),
		.rt      (ctrl.rt),
		.wr_en   (reg_wr_en),
		.wr_data (wb_value),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.rt_data (rt_data)
	);

	// imem_addr is the current pc
	execute_unit execute_unit_inst (
		.ctrl          (ctrl),
		.pc            (imem_addr),
		.ra_data       (ra_data),
		.rb_data       (rb_data),
		.rt_data       (rt_data),
		.load_data     (load_data),
		.mem_addr      (mem_addr),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.wb_value      (wb_value)
	);

endmodule

`default_nettype wire

/* source/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	localparam int xlen = 32;
	localparam int reg_count = 32;
	localparam int reg_addr_width = 5;
	localparam int imm_width = 24;
	localparam logic [xlen-1:0] pc_step = 32'd4;

	// major opcode, instruction bits 30:25
	typedef enum logic [5:0] {
		ty_base = 6'b100000,
		addi    = 6'b101000,
		ori     = 6'b101100,
		xori    = 6'b101011,
		movi    = 6'b100010,
		lwi     = 6'b000010,
		swi     = 6'b001010,
		ty_ls   = 6'b011100,
		ty_b    = 6'b100110,
		jj      = 6'b100100
	} opcode_t;

	// ty_base sub-opcode, bits 4:0
	typedef enum logic [4:0] {
		add    = 5'b00000,
		sub    = 5'b00001,
		and_op = 5'b00010,
		xor_op = 5'b00011,
		or_op  = 5'b00100,
		slli   = 5'b01000,
		srli   = 5'b01001,
		rotri  = 5'b01011
	} base_subop_t;

	// ty_ls sub-opcode, bits 7:0
	typedef enum logic [7:0] {
		lw = 8'b00000010,
		sw = 8'b00001010
	} ls_subop_t;

	typedef enum logic [2:0] {
		fetch,
		decode,
		execute,
		memaccess,
		writeback
	} phase_t;

	typedef enum logic [2:0] {
		src2_rb_data,
		src2_imm,
		src2_lsw_index,
		src2_lswi_offset,
		src2_branch,
		src2_none
	} alu_src2_t;

	typedef enum logic [2:0] {
		ext_imm5_ze,
		ext_imm15_se,
		ext_imm15_ze,
		ext_imm20_se,
		ext_none
	} imm_ext_t;

	typedef enum logic [1:0] {
		wb_alu_result,
		wb_imm_data,
		wb_load_data,
		wb_none
	} wb_src_t;

	typedef enum logic [3:0] {
		alu_pass,
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_srl,
		alu_sll,
		alu_rotr
	} alu_op_t;

	// one decoded instruction
	typedef struct packed {
		alu_op_t alu_op;
		alu_src2_t alu_src2;
		imm_ext_t imm_ext;
		wb_src_t wb_src;
		logic dm_read;
		logic dm_write;
		logic reg_write;
		logic is_branch;
		logic branch_ne;
		logic is_jump;
		logic [1:0] sv;
		logic [reg_addr_width-1:0] ra;
		logic [reg_addr_width-1:0] rb;
		logic [reg_addr_width-1:0] rt;
		logic [imm_width-1:0] imm;
	} ctrl_t;

	typedef struct packed {
		logic [xlen-1:0] addr;
		logic [xlen-1:0] wdata;
		logic write;
	} mem_req_t;

endpackage

`default_nettype wire

/* source/execute_unit.sv */
`default_nettype none

module execute_unit
	import cpu_pkg::*;
(
	input  ctrl_t           ctrl,
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] ra_data,
	input  logic [xlen-1:0] rb_data,
	input  logic [xlen-1:0] rt_data,
	input  logic [xlen-1:0] load_data,
	output logic [xlen-1:0] mem_addr,
	output logic            branch_taken,
	output logic [xlen-1:0] branch_target,
	output logic [xlen-1:0] wb_value
);

	logic [xlen-1:0] imm_value;
	logic [xlen-1:0] operand2;
	logic [xlen-1:0] alu_result;
	logic [2*xlen-1:0] rot_wide;
	logic [4:0] shamt;
	logic [xlen-1:0] branch_offset;
	logic [xlen-1:0] jump_offset;
	logic operands_equal;

	always_comb begin
		case (ctrl.imm_ext)
			ext_imm5_ze:  imm_value = xlen'(ctrl.imm[14:10]);
			ext_imm15_se: imm_value = xlen'(signed'(ctrl.imm[14:0]));
			ext_imm15_ze: imm_value = xlen'(ctrl.imm[14:0]);
			ext_imm20_se: imm_value = xlen'(signed'(ctrl.imm[19:0]));
			default:      imm_value = '0;
		endcase
	end

	always_comb begin
		case (ctrl.alu_src2)
			src2_rb_data:     operand2 = rb_data;
			src2_imm:         operand2 = imm_value;
			src2_lsw_index:   operand2 = rb_data << ctrl.sv;
			src2_lswi_offset: operand2 = xlen'(signed'(ctrl.imm[14:0])) << 2;
			// branch compares rt against ra
			src2_branch:      operand2 = rt_data;
			default:          operand2 = '0;
		endcase
	end

	assign shamt = operand2[4:0];
	assign rot_wide = {ra_data, ra_data} >> shamt;

	always_comb begin
		case (ctrl.alu_op)
			alu_add:  alu_result = ra_data + operand2;
			alu_sub:  alu_result = ra_data - operand2;
			alu_and:  alu_result = ra_data & operand2;
			alu_or:   alu_result = ra_data | operand2;
			alu_xor:  alu_result = ra_data ^ operand2;
			alu_srl:  alu_result = ra_data >> shamt;
			alu_sll:  alu_result = ra_data << shamt;
			alu_rotr: alu_result = rot_wide[xlen-1:0];
			default:  alu_result = operand2;
		endcase
	end

	// loads and stores set up an add
	assign mem_addr = alu_result;

	assign operands_equal = (alu_result == '0);
	assign branch_offset = xlen'(signed'(ctrl.imm[13:0])) << 1;
	// jump is pc relative too
	assign jump_offset = xlen'(signed'(ctrl.imm[23:0])) << 1;

	assign branch_taken = ctrl.is_jump ||
		(ctrl.is_branch && (ctrl.branch_ne ? !operands_equal : operands_equal));
	assign branch_target = ctrl.is_jump ? pc + jump_offset : pc + branch_offset;

	always_comb begin
		case (ctrl.wb_src)
			wb_alu_result: wb_value = alu_result;
			wb_imm_data:   wb_value = imm_value;
			wb_load_data:  wb_value = load_data;
			default:       wb_value = '0;
		endcase
	end

endmodule

`default_nettype wire

/* source/register_file.sv */
`default_nettype none

module register_file
	import cpu_pkg::*;
(
	input  logic                      clock,
	input  logic                      reset,
	input  logic [reg_addr_width-1:0] ra,
	input  logic [reg_addr_width-1:0] rb,
	input  logic [reg_addr_width-1:0] rt,
	input  logic                      wr_en,
	input  logic [xlen-1:0]           wr_data,
	output logic [xlen-1:0]           ra_data,
	output logic [xlen-1:0]           rb_data,
	output logic [xlen-1:0]           rt_data
);

	logic [xlen-1:0] regs [reg_count];

	// writes always target rt
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[rt] <= wr_data;
		end
	end

	// asynchronous reads
	assign ra_data = regs[ra];
	assign rb_data = regs[rb];
	assign rt_data = regs[rt];

endmodule

`default_nettype wire

/* tb.f */
+incdir+verification
source/cpu_pkg.sv
source/controller.sv
source/register_file.sv
source/execute_unit.sv
source/cpu_core.sv
verification/cpu_tb.sv

/* verification/cpu_tb_tests.svh */
// register forms on movi and addi operands with results stored by swi
task automatic test_alu_ops();
	base_subop_t ops [5];
	logic [19:0] a20;
	logic [14:0] b15;
	logic [xlen-1:0] a;
	logic [xlen-1:0] b;
	logic [xlen-1:0] want [5];
	ops = '{add, sub, and_op, or_op, xor_op};
	a20 = 20'(lfsr_bits(20));
	b15 = 15'(lfsr_bits(15));
	a = {{12{a20[19]}}, a20};
	b = a + {{17{b15[14]}}, b15};
	want = '{a + b, a - b, a & b, a | b, a ^ b};
	clear_memories();
	prog[0] = {1'b0, movi, 5'd1, a20};
	prog[1] = {1'b0, addi, 5'd2, 5'd1, b15};
	for (int i = 0; i < 5; i++) begin
		prog[2 + i] = {1'b0, ty_base, 5'(3 + i), 5'd1, 5'd2, 5'd0, ops[i]};
		prog[7 + i] = {1'b0, swi, 5'(3 + i), 5'd0, 15'(64 + i)};
	end
	run_program(32'd48);
	check_equal(store_log.size(), 5, "alu store count");
	for (int i = 0; i < 5; i++) begin
		check_equal(store_log[i], {32'((64 + i) * 4), want[i]}, "alu result store");
	end
endtask

task automatic test_immediates();
	logic [19:0] a20;
	logic [14:0] i15;
	logic [4:0] amt;
	logic [xlen-1:0] a;
	logic [xlen-1:0] want [7];
	// top bits set so sign and zero extension differ
	a20 = {1'b1, 19'(lfsr_bits(19))};
	i15 = {1'b1, 14'(lfsr_bits(14))};
	// nonzero so the three shift forms differ
	amt = 5'd1 + 5'(lfsr_bits(4));
	a = {12'hfff, a20};
	want = '{a, a >> amt, a << amt, (a >> amt) | (a << (32 - amt)),
		a | {17'd0, i15}, a ^ {17'd0, i15}, {17'h1ffff, i15}};
	clear_memories();
	prog[0] = {1'b0, movi, 5'd1, a20};
	prog[1] = {1'b0, ty_base, 5'd2, 5'd1, amt, 5'd0, srli};
	prog[2] = {1'b0, ty_base, 5'd3, 5'd1, amt, 5'd0, slli};
	prog[3] = {1'b0, ty_base, 5'd4, 5'd1, amt, 5'd0, rotri};
	prog[4] = {1'b0, ori, 5'd5, 5'd1, i15};
	prog[5] = {1'b0, xori, 5'd6, 5'd1, i15};
	prog[6] = {1'b0, addi, 5'd7, 5'd0, i15};
	for (int i = 0; i < 7; i++) begin
		prog[7 + i] = {1'b0, swi, 5'(1 + i), 5'd0, 15'(96 + i)};
	end
	run_program(32'd56);
	check_equal(store_log.size(), 7, "immediate store count");
	for (int i = 0; i < 7; i++) begin
		check_equal(store_log[i], {32'((96 + i) * 4), want[i]}, "immediate result store");
	end
endtask

task automatic test_loads_stores();
	logic [xlen-1:0] preset;
	preset = lfsr_bits(32);
	clear_memories();
	data_mem[32'h110] = preset;
	prog[0] = {1'b0, movi, 5'd1, 20'h100};
	prog[1] = {1'b0, movi, 5'd2, 20'd4};
	// offset of -2 words reads 0xf8
	prog[2] = {1'b0, lwi, 5'd3, 5'd1, 15'h7ffe};
	prog[3] = {1'b0, ty_ls, 5'd4, 5'd1, 5'd2, 2'd2, lw};
	prog[4] = {1'b0, swi, 5'd3, 5'd1, 15'd5};
	prog[5] = {1'b0, ty_ls, 5'd4, 5'd1, 5'd2, 2'd1, sw};
	run_program(32'd24);
	check_equal(dmem_count, 4, "data request count");
	check_equal(store_log[0], {32'h114, read_word(32'hf8)}, "swi store");
	check_equal(store_log[1], {32'h108, preset}, "sw store");
endtask

task automatic test_branches();
	logic [xlen-1:0] want [9];
	clear_memories();
	prog[0] = {1'b0, movi, 5'd1, 20'd5};
	prog[1] = {1'b0, movi, 5'd2, 20'd5};
	prog[2] = {1'b0, ty_b, 5'd2, 5'd1, 1'b0, 14'd6};
	prog[5] = {1'b0, ty_b, 5'd2, 5'd1, 1'b1, 14'd6};
	prog[6] = {1'b0, movi, 5'd3, 20'd7};
	prog[7] = {1'b0, ty_b, 5'd3, 5'd1, 1'b1, 14'd6};
	prog[10] = {1'b0, ty_b, 5'd3, 5'd1, 1'b0, 14'd6};
	prog[11] = {1'b0, jj, 1'b0, 24'd8};
	run_program(32'd60);
	want = '{0, 4, 8, 20, 24, 28, 40, 44, 60};
	check_equal(fetch_log.size(), 9, "branch fetch count");
	foreach (want[i]) begin
		check_equal(fetch_log[i], want[i], "branch fetch address");
	end
endtask

task automatic test_undefined();
	logic [19:0] v20;
	logic [xlen-1:0] want [6];
	v20 = 20'(lfsr_bits(20));
	clear_memories();
	prog[0] = {1'b0, movi, 5'd1, v20};
	prog[1] = {1'b0, 6'b111111, 5'd1, 20'(lfsr_bits(20))};
	prog[2] = {1'b0, ty_base, 5'd1, 5'd0, 5'd0, 5'd0, 5'b11111};
	prog[3] = {1'b0, ty_ls, 5'd1, 5'd0, 5'd0, 2'd0, 8'hff};
	prog[4] = {1'b0, swi, 5'd1, 5'd0, 15'd32};
	run_program(32'd20);
	want = '{0, 4, 8, 12, 16, 20};
	foreach (want[i]) begin
		check_equal(fetch_log[i], want[i], "fetch address after no-op");
	end
	check_equal(dmem_count, 1, "data request count");
	check_equal(store_log[0], {32'h80, {12{v20[19]}}, v20}, "store after no-ops");
endtask

/* verification/cpu_tb.sv */
`default_nettype none

module cpu_tb
	import cpu_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int clock_period = 100;
	localparam int reset_cycles = 16;
	localparam int run_limit = 600;
	localparam int test_count = 5;

	typedef struct packed {
		logic [xlen-1:0] addr;
		logic [xlen-1:0] data;
	} store_t;

	logic clock;
	logic reset;
	logic imem_req;
	logic [xlen-1:0] imem_addr;
	logic imem_ack;
	logic [xlen-1:0] imem_rdata;
	logic dmem_req;
	mem_req_t dmem_out;
	logic dmem_ack;
	logic [xlen-1:0] dmem_rdata;

	logic [xlen-1:0] prog [256];
	logic [xlen-1:0] data_mem [logic [xlen-1:0]];
	logic [xlen-1:0] fetch_log [$];
	store_t store_log [$];
	logic [xlen-1:0] stop_addr;
	logic halted;
	logic [31:0] lfsr_state = 32'h396d;
	int dmem_count;
	int checks;
	int errors;

	cpu_core cpu_core_inst (.*);

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_bits(input int count);
		logic [31:0] bits;
		logic feedback;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], feedback};
			bits = {bits[30:0], feedback};
		end
		return bits;
	endfunction

	// unwritten words read back as a pattern of their own address
	function automatic logic [xlen-1:0] read_word(input logic [xlen-1:0] addr);
		if (data_mem.exists(addr)) begin
			return data_mem[addr];
		end
		return addr ^ 32'hc3a5_0f96;
	endfunction

	task automatic check_equal(input logic [63:0] got, input logic [63:0] want,
			input string what);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	// one ack delay cycle, the request has to stay up
	task automatic delay_cycle(input logic data_bus);
		@(negedge clock);
		assert (reset || (data_bus ? dmem_req : imem_req)) else begin
			errors++;
			$display("a request on the %s bus dropped before its ack",
				data_bus ? "data" : "instruction");
		end
	endtask

	task automatic clear_memories();
		foreach (prog[i]) begin
			prog[i] = '0;
		end
		data_mem.delete();
	endtask

	task automatic run_program(input logic [xlen-1:0] stop);
		int cycles;
		@(negedge clock);
		reset = 1'b1;
		stop_addr = stop;
		halted = 1'b0;
		fetch_log.delete();
		store_log.delete();
		dmem_count = 0;
		repeat (reset_cycles) @(negedge clock);
		reset = 1'b0;
		cycles = 0;
		while (!halted && cycles < run_limit) begin
			@(posedge clock);
			cycles++;
		end
		assert (halted) else begin
			errors++;
			$display("program never fetched address %h within %0d cycles", stop, run_limit);
		end
	endtask

	// answers one request at a time, the stop fetch is left unanswered
	initial begin : memory_model
		logic [1:0] delay;
		forever begin
			@(negedge clock);
			if (!reset && !halted && imem_req) begin
				fetch_log.push_back(imem_addr);
				check_equal(imem_addr[1:0], 2'b00, "fetch address alignment");
				if (imem_addr == stop_addr) begin
					halted = 1'b1;
				end else begin
					delay = 2'(lfsr_bits(2));
					repeat (delay) delay_cycle(1'b0);
					imem_rdata = prog[imem_addr[9:2]];
					imem_ack = 1'b1;
					while (imem_req) @(negedge clock);
					imem_ack = 1'b0;
				end
			end else if (!reset && dmem_req) begin
				dmem_count++;
				delay = 2'(lfsr_bits(2));
				repeat (delay) delay_cycle(1'b1);
				if (dmem_out.write) begin
					store_log.push_back({dmem_out.addr, dmem_out.wdata});
					data_mem[dmem_out.addr] = dmem_out.wdata;
				end else begin
					dmem_rdata = read_word(dmem_out.addr);
				end
				dmem_ack = 1'b1;
				while (dmem_req) @(negedge clock);
				dmem_ack = 1'b0;
			end
		end
	end

	// every run is bounded by reset plus run_limit cycles
	initial begin
		#(test_count * (reset_cycles + run_limit + 8) * clock_period);
		$display("watchdog expired before the tests finished");
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		reset = 1'b1;
		imem_ack = 1'b0;
		imem_rdata = '0;
		dmem_ack = 1'b0;
		dmem_rdata = '0;
		halted = 1'b0;
		stop_addr = '0;
		dmem_count = 0;
		checks = 0;
		errors = 0;
		test_alu_ops();
		test_immediates();
		test_loads_stores();
		test_branches();
		test_undefined();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	`include "cpu_tb_tests.svh"

endmodule

`default_nettype wire
